//--- Bender.yml
package:
  name: proc

export_include_dirs:
  - design

sources:
  - design/proc_pkg.sv
  - design/decode.sv
  - design/exec_alu.sv
  - design/branch_unit.sv
  - design/commit.sv
  - design/proc.sv
  - target: test
    files:
      - dv/proc_tb.sv

//--- design/branch_unit.sv
// branch unit computing next PC, branch target and the compare-to-zero taken decision
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module branch_unit import proc_pkg::*; (
    input  wire ctrl_t                 ctrl,
    input  wire logic [`PROC_XLEN-1:0] pc,
    input  wire logic [`PROC_XLEN-1:0] rs_data,
    input  wire logic [`PROC_XLEN-1:0] imm,
    output logic [`PROC_XLEN-1:0]      next_pc,
    output logic                       taken
);

    logic [`PROC_XLEN-1:0] pc_plus2;
    logic [`PROC_XLEN-1:0] target;
    logic                  rs_zero;
    logic                  rs_neg;

    // sequential fetch
    assign pc_plus2 = pc + `PROC_XLEN'(2);

    // offset counts instructions so it is scaled by two
    assign target = pc_plus2 + {imm[`PROC_XLEN-2:0], 1'b0};

    assign rs_zero = (rs_data == '0);
    assign rs_neg  = rs_data[`PROC_XLEN-1];

    always_comb begin
        case (ctrl.branch_kind)
            br_eqz:  taken = rs_zero;
            br_gtz:  taken = !rs_zero && !rs_neg;
            br_ltz:  taken = rs_neg;
            default: taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? target : pc_plus2;

    // a taken branch is never a HALT or illegal word
    a_taken_on_branch: assert final (!taken || (!ctrl.halt && !ctrl.illegal));

endmodule

`default_nettype wire

//--- design/commit.sv
// commit: data memory, write-back select, PC register, halt and error state, retire trace
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module commit import proc_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire ctrl_t                 ctrl,
    input  wire logic [`PROC_XLEN-1:0] alu_result,
    input  wire logic [`PROC_XLEN-1:0] rt_data,
    input  wire logic [`PROC_XLEN-1:0] next_pc,
    input  wire logic                  taken,
    output logic [`PROC_XLEN-1:0]      pc,
    output logic                       wr_en,
    output reg_idx_t                   wr_reg,
    output logic [`PROC_XLEN-1:0]      wr_data,
    output retire_t                    retire,
    output logic                       halted,
    output logic                       err
);

    localparam int AW = $clog2(`PROC_DMEM_DEPTH);

    logic [`PROC_XLEN-1:0] dmem [`PROC_DMEM_DEPTH];
    logic [AW-1:0]         dmem_addr;
    logic [`PROC_XLEN-1:0] mem_rdata;
    logic                  mem_we;

    //////////////////////////////////////////////////
    // data memory, word addressed, wraps at depth
    //////////////////////////////////////////////////
    assign dmem_addr = alu_result[AW-1:0];
    assign mem_rdata = ctrl.mem_read ? dmem[dmem_addr] : '0;
    assign mem_we    = ctrl.mem_write && !halted;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `PROC_DMEM_DEPTH; k++) begin
                dmem[k] <= '0;
            end
        end else if (mem_we) begin
            dmem[dmem_addr] <= rt_data;
        end
    end

    // write-back select, frozen once halted
    assign wr_en   = ctrl.reg_write && !halted;
    assign wr_reg  = ctrl.rd;
    assign wr_data = (ctrl.wr_sel == wb_mem) ? mem_rdata : alu_result;

    //////////////////////////////////////////////////
    // pc, halt and sticky error
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= '0;
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (!halted) begin
            // pc stays on the HALT word
            if (!ctrl.halt) begin
                pc <= next_pc;
            end
            halted <= ctrl.halt;
            err    <= err | ctrl.illegal;
        end
    end

    // trace of the current instruction
    always_comb begin
        retire        = '0;
        retire.valid  = !halted;
        retire.reg_we = wr_en;
        if (wr_en) begin
            retire.rd   = wr_reg;
            retire.data = wr_data;
        end
    end

    // sticky until reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted);

    // a taken branch never touches registers or memory
    a_branch_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        taken |-> !ctrl.reg_write && !ctrl.mem_write);

endmodule

`default_nettype wire

//--- design/decode.sv
// decode: maps opcodes to control and holds the register file with two read ports
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module decode import proc_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire instr_u                instr,
    input  wire logic                  wr_en,
    input  wire reg_idx_t              wr_reg,
    input  wire logic [`PROC_XLEN-1:0] wr_data,
    output ctrl_t                      ctrl,
    output logic [`PROC_XLEN-1:0]      rs_data,
    output logic [`PROC_XLEN-1:0]      rt_data,
    output logic [`PROC_XLEN-1:0]      imm
);

    logic [`PROC_XLEN-1:0] regs [`PROC_NREGS];

    //////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////
    always_comb begin
        ctrl       = '0;
        // I format destination unless the opcode says otherwise
        ctrl.rd    = instr.i.rd;
        ctrl.funct = instr.r.funct;
        case (instr.r.opcode)
            op_alu: begin
                ctrl.reg_write = 1'b1;
                ctrl.rd        = instr.r.rd;
                ctrl.alu_kind  = ak_arith;
            end
            op_shift: begin
                ctrl.reg_write = 1'b1;
                ctrl.rd        = instr.r.rd;
                ctrl.alu_kind  = ak_shift;
            end
            op_ldi: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_kind  = ak_pass;
            end
            op_addi: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_kind  = ak_add;
            end
            op_ld: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_kind  = ak_add;
                ctrl.mem_read  = 1'b1;
                ctrl.wr_sel    = wb_mem;
            end
            op_st: begin
                // address is rd plus imm, data comes from the rt port
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_kind  = ak_add;
            end
            op_beqz: ctrl.branch_kind = br_eqz;
            op_bgtz: ctrl.branch_kind = br_gtz;
            op_bltz: ctrl.branch_kind = br_ltz;
            op_halt: ctrl.halt = 1'b1;
            // unknown opcode, retire as a no-op and flag it
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // sign-extended 8-bit immediate
    assign imm = {{(`PROC_XLEN-8){instr.i.imm8[7]}}, instr.i.imm8};

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////
    // rs field sits where the I format keeps rd
    assign rs_data = regs[instr.r.rs];
    // ST data register shares bits 7:5 with the immediate
    assign rt_data = regs[instr.r.rt];

    // write lands at the edge, no bypass needed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `PROC_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // one instruction never writes both a register and memory
    a_no_dual_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(ctrl.reg_write && ctrl.mem_write));

endmodule

`default_nettype wire

//--- design/exec_alu.sv
// exec_alu: ALU and shifter producing the data result from registers or immediate
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module exec_alu import proc_pkg::*; (
    input  wire ctrl_t                 ctrl,
    input  wire logic [`PROC_XLEN-1:0] rs_data,
    input  wire logic [`PROC_XLEN-1:0] rt_data,
    input  wire logic [`PROC_XLEN-1:0] imm,
    output logic [`PROC_XLEN-1:0]      alu_result
);

    localparam int SHW = $clog2(`PROC_XLEN);

    logic [`PROC_XLEN-1:0]   operand_b;
    logic [SHW-1:0]          shamt;
    logic [2*`PROC_XLEN-1:0] rot_wide;

    // second operand mux
    assign operand_b = ctrl.use_imm ? imm : rt_data;

    // shift count from low bits of rt
    assign shamt = rt_data[SHW-1:0];

    // rotate via doubled word, upper half is the result
    assign rot_wide = {rs_data, rs_data} << shamt;

    always_comb begin
        alu_result = '0;
        case (ctrl.alu_kind)
            ak_arith: begin
                case (ctrl.funct)
                    2'b00: alu_result = rs_data + operand_b;
                    2'b01: alu_result = rs_data - operand_b;
                    2'b10: alu_result = rs_data & operand_b;
                    2'b11: alu_result = rs_data ^ operand_b;
                endcase
            end
            ak_shift: begin
                case (ctrl.funct)
                    2'b00: alu_result = rs_data << shamt;
                    2'b01: alu_result = rs_data >> shamt;
                    // arithmetic right keeps the sign
                    2'b10: alu_result = $signed(rs_data) >>> shamt;
                    2'b11: alu_result = rot_wide[2*`PROC_XLEN-1:`PROC_XLEN];
                endcase
            end
            // ADDI and the LD/ST word address
            ak_add:  alu_result = rs_data + operand_b;
            // LDI
            ak_pass: alu_result = operand_b;
        endcase
    end

endmodule

`default_nettype wire

//--- design/proc.sv
// proc: single-cycle 16-bit core wiring decode, execute, branch and commit
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module proc import proc_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    output logic [`PROC_XLEN-1:0]      imem_addr,
    input  wire instr_u                imem_data,
    output retire_t                    retire,
    output logic                       halted,
    output logic                       err
);

    ctrl_t                 ctrl;
    logic [`PROC_XLEN-1:0] rs_data;
    logic [`PROC_XLEN-1:0] rt_data;
    logic [`PROC_XLEN-1:0] imm;
    logic [`PROC_XLEN-1:0] alu_result;
    logic [`PROC_XLEN-1:0] next_pc;
    logic                  taken;
    logic [`PROC_XLEN-1:0] pc;
    logic                  wr_en;
    reg_idx_t              wr_reg;
    logic [`PROC_XLEN-1:0] wr_data;

    // fetch address straight from the pc register
    assign imem_addr = pc;

    decode decode_inst (
        .clk, .arst_n, .instr(imem_data), .wr_en, .wr_reg, .wr_data,
        .ctrl, .rs_data, .rt_data, .imm
    );

    exec_alu exec_alu_inst (.ctrl, .rs_data, .rt_data, .imm, .alu_result);

    branch_unit branch_unit_inst (.ctrl, .pc, .rs_data, .imm, .next_pc, .taken);

    commit commit_inst (
        .clk, .arst_n, .ctrl, .alu_result, .rt_data, .next_pc, .taken,
        .pc, .wr_en, .wr_reg, .wr_data, .retire, .halted, .err
    );

endmodule

`default_nettype wire

//--- design/proc_cfg.svh
// proc configuration defines for word width, register count and data memory size

`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// datapath word width in bits
`define PROC_XLEN 16

// general purpose registers, no hardwired zero
`define PROC_NREGS 8

// data memory words, any power of two
`define PROC_DMEM_DEPTH 64

`endif

//--- design/proc_pkg.sv
// proc package with opcodes, instruction formats and datapath control types
`default_nettype none

package proc_pkg;

    `include "proc_cfg.svh"

    //////////////////////////////////////////////////
    // opcodes, anything not listed traps as illegal
    //////////////////////////////////////////////////
    typedef enum logic [4:0] {
        op_halt  = 5'b00000,
        op_addi  = 5'b01000,
        op_beqz  = 5'b01100,
        op_bgtz  = 5'b01101,
        op_bltz  = 5'b01110,
        op_st    = 5'b10000,
        op_ld    = 5'b10001,
        op_ldi   = 5'b11000,
        op_shift = 5'b11010,
        op_alu   = 5'b11011
    } opcode_e;

    typedef logic [2:0] reg_idx_t;

    // three register format
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [1:0] funct;
    } instr_r_t;

    // register plus 8-bit immediate format
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        logic [7:0] imm8;
    } instr_i_t;

    // same fetched word, viewed either way
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    //////////////////////////////////////////////////
    // control word from decode
    //////////////////////////////////////////////////
    typedef enum logic {wb_alu, wb_mem} wb_sel_e;
    typedef enum logic [1:0] {ak_arith, ak_shift, ak_add, ak_pass} alu_kind_e;
    typedef enum logic [1:0] {br_none, br_eqz, br_gtz, br_ltz} branch_kind_e;

    typedef struct packed {
        logic         reg_write;
        reg_idx_t     rd;
        wb_sel_e      wr_sel;
        logic         mem_read;
        logic         mem_write;
        logic         use_imm;
        alu_kind_e    alu_kind;
        logic [1:0]   funct;
        branch_kind_e branch_kind;
        logic         halt;
        logic         illegal;
    } ctrl_t;

    // one retired instruction, zero latency
    typedef struct packed {
        logic                  valid;
        reg_idx_t              rd;
        logic                  reg_we;
        logic [`PROC_XLEN-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

//--- dv/proc_tb.sv
// random program testbench checking the proc core against an ISA model
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module proc_tb import proc_pkg::*; ();

    logic                  clk;
    logic                  arst_n;
    logic [`PROC_XLEN-1:0] imem_addr;
    instr_u                imem_data;
    retire_t               retire;
    logic                  halted;
    logic                  err;

    // program store holding one instruction per word address
    instr_u prog [256];

    // shadow architectural state
    logic [`PROC_XLEN-1:0] m_regs [`PROC_NREGS];
    logic [`PROC_XLEN-1:0] m_mem [`PROC_DMEM_DEPTH];
    logic [`PROC_XLEN-1:0] m_pc;
    logic                  m_halted;
    logic                  m_err;
    retire_t               exp_retire;

    int          errors;
    int          tests;
    int          failed;

    proc proc_inst (
        .clk, .arst_n, .imem_addr, .imem_data, .retire, .halted, .err
    );

    always #5 clk = ~clk;

    // instruction port answered within the cycle
    always @(negedge clk) begin
        imem_data <= prog[imem_addr[8:1]];
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("Error at %0t: %s expected %h, got %h", $time, sig, exp, got);
    endtask

    //////////////////////////////////////////////////
    // reference ISA model
    //////////////////////////////////////////////////
    function automatic void model_reset();
        for (int k = 0; k < `PROC_NREGS; k++) begin
            m_regs[k] = '0;
        end
        for (int k = 0; k < `PROC_DMEM_DEPTH; k++) begin
            m_mem[k] = '0;
        end
        m_pc     = '0;
        m_halted = 1'b0;
        m_err    = 1'b0;
    endfunction

    // executes one instruction and returns its expected trace
    function automatic retire_t step_model();
        instr_u                w;
        retire_t               r;
        logic [`PROC_XLEN-1:0] a;
        logic [`PROC_XLEN-1:0] b;
        logic [`PROC_XLEN-1:0] imm;
        logic [`PROC_XLEN-1:0] res;
        logic [`PROC_XLEN-1:0] next;
        logic [2:0]            rd;
        int unsigned           sh;
        bit                    we;
        bit                    take;
        r = '0;
        if (m_halted) begin
            return r;
        end
        w    = prog[m_pc[8:1]];
        a    = m_regs[w.r.rs];
        b    = m_regs[w.r.rt];
        imm  = `PROC_XLEN'($signed(w.i.imm8));
        sh   = b[3:0];
        next = m_pc + 2;
        rd   = w.i.rd;
        res  = '0;
        we   = 1'b0;
        take = 1'b0;
        case (w.r.opcode)
            op_alu: begin
                we = 1'b1;
                rd = w.r.rd;
                case (w.r.funct)
                    2'd0: res = a + b;
                    2'd1: res = a - b;
                    2'd2: res = a & b;
                    default: res = a ^ b;
                endcase
            end
            op_shift: begin
                we = 1'b1;
                rd = w.r.rd;
                case (w.r.funct)
                    2'd0: res = a << sh;
                    2'd1: res = a >> sh;
                    2'd2: res = $signed(a) >>> sh;
                    default: res = (a << sh) | (a >> (`PROC_XLEN - sh));
                endcase
            end
            op_ldi: begin
                we  = 1'b1;
                res = imm;
            end
            op_addi: begin
                we  = 1'b1;
                res = m_regs[w.i.rd] + imm;
            end
            op_ld: begin
                we  = 1'b1;
                res = m_mem[(m_regs[w.i.rd] + imm) % `PROC_DMEM_DEPTH];
            end
            // store data register overlaps imm8[7:5]
            op_st: m_mem[(m_regs[w.i.rd] + imm) % `PROC_DMEM_DEPTH] = m_regs[w.i.imm8[7:5]];
            op_beqz: take = (m_regs[w.i.rd] == 0);
            op_bgtz: take = ($signed(m_regs[w.i.rd]) > 0);
            op_bltz: take = ($signed(m_regs[w.i.rd]) < 0);
            op_halt: begin
                m_halted = 1'b1;
                next     = m_pc;
            end
            default: m_err = 1'b1;
        endcase
        // offset counted in instructions
        if (take) begin
            next = m_pc + 2 + imm * 2;
        end
        if (we) begin
            m_regs[rd] = res;
            r.reg_we   = 1'b1;
            r.rd       = rd;
            r.data     = res;
        end
        r.valid = 1'b1;
        m_pc    = next;
        return r;
    endfunction

    // compare the current cycle and then advance the model
    always @(posedge clk) begin
        if (arst_n) begin
            assert (imem_addr === m_pc) else report_mismatch("imem_addr", m_pc, imem_addr);
            assert (halted === m_halted) else report_mismatch("halted", m_halted, halted);
            assert (err === m_err) else report_mismatch("err", m_err, err);
            exp_retire = step_model();
            assert (retire === exp_retire) else report_mismatch("retire", exp_retire, retire);
        end
    end

    //////////////////////////////////////////////////
    // program generation
    //////////////////////////////////////////////////
    function automatic instr_u enc_i(input opcode_e op, input int rd, input int imm);
        instr_u w;
        w.i.opcode = op;
        w.i.rd     = 3'(rd);
        w.i.imm8   = 8'(imm);
        return w;
    endfunction

    // random ALU, SHIFT, LDI or ADDI with destination limited to max_rd
    function automatic instr_u rand_arith(input int max_rd);
        instr_u w;
        w = `PROC_XLEN'($urandom);
        case ($urandom_range(3))
            0: w.r.opcode = op_alu;
            1: w.r.opcode = op_shift;
            2: w.i.opcode = op_ldi;
            default: w.i.opcode = op_addi;
        endcase
        // destination sits in a different field per format
        if (w.r.opcode == op_alu || w.r.opcode == op_shift) begin
            w.r.rd = 3'($urandom_range(max_rd));
        end else begin
            w.i.rd = 3'($urandom_range(max_rd));
        end
        return w;
    endfunction

    function automatic bit is_legal(input logic [4:0] op);
        case (op)
            op_halt, op_addi, op_beqz, op_bgtz, op_bltz,
            op_st, op_ld, op_ldi, op_shift, op_alu: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic instr_u rand_illegal();
        instr_u     w;
        logic [4:0] op;
        w  = `PROC_XLEN'($urandom);
        op = 5'($urandom);
        while (is_legal(op)) begin
            op = 5'($urandom);
        end
        w.r.opcode = opcode_e'(op);
        return w;
    endfunction

    task automatic build_program(input int kind);
        int i;
        int n;
        int s;
        int off;
        int dir;
        // unused words halt the core
        for (i = 0; i < 256; i++) begin
            prog[i] = '0;
        end
        case (kind)
            0: for (i = 0; i < 200; i++) prog[i] = rand_arith(7);
            1: begin
                for (i = 0; i < 8; i++) prog[i] = enc_i(op_ldi, i, $urandom);
                while (i < 200) begin
                    n   = $urandom_range(7);
                    off = $urandom;
                    s   = $urandom_range(7);
                    if (n < 2) begin
                        prog[i] = rand_arith(7);
                        i++;
                    end else if (n < 6) begin
                        // store then reload through the same base and offset
                        prog[i]     = enc_i(op_st, s, off);
                        prog[i + 1] = enc_i(op_ld, s, off);
                        i += 2;
                    end else begin
                        prog[i] = enc_i(op_ld, s, off);
                        i++;
                    end
                end
            end
            2: begin
                for (i = 0; i < 7; i++) prog[i] = enc_i(op_ldi, i, $urandom);
                while (i < 200) begin
                    if ($urandom_range(2) != 0) begin
                        // counted loop on r7 closed by a backward branch
                        n   = $urandom_range(1, 3);
                        off = $urandom_range(1, 3);
                        dir = $urandom_range(1);
                        prog[i] = enc_i(op_ldi, 7, dir ? -off : off);
                        s = i + 1;
                        for (int k = 0; k < n; k++) prog[s + k] = rand_arith(6);
                        prog[s + n]     = enc_i(op_addi, 7, dir ? 1 : -1);
                        prog[s + n + 1] = enc_i(dir ? op_bltz : op_bgtz, 7, -(n + 2));
                        i = s + n + 2;
                    end else begin
                        // forward skip over a few words
                        off = $urandom_range(1, 3);
                        n   = $urandom_range(2);
                        prog[i] = enc_i(n == 0 ? op_beqz : (n == 1 ? op_bgtz : op_bltz),
                                        $urandom_range(6), off);
                        for (int k = 1; k <= off; k++) prog[i + k] = rand_arith(6);
                        i = i + off + 1;
                    end
                end
            end
            3: begin
                for (i = 0; i < 30; i++) prog[i] = rand_arith(7);
                // words past the HALT must never run
                for (i = 31; i < 60; i++) prog[i] = rand_arith(7);
            end
            4: begin
                for (i = 0; i < 200; i++) begin
                    prog[i] = ($urandom_range(7) == 0) ? rand_illegal() : rand_arith(7);
                end
                prog[3] = rand_illegal();
            end
            default: begin
                // spill every register to memory and reload each into r0
                for (i = 0; i < 8; i++) begin
                    prog[i]     = enc_i(op_st, 0, i * 33);
                    prog[i + 8] = enc_i(op_ld, 0, i * 33);
                end
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // test sequencing
    //////////////////////////////////////////////////
    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        model_reset();
        @(negedge clk);
        assert (imem_addr == 0 && !halted && !err) else begin
            errors++;
            $display("reset did not clear imem_addr, halted and err at %0t", $time);
        end
        repeat (15) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // run to HALT and then watch the frozen core
    task automatic finish_run(input string name);
        int                    n;
        logic [`PROC_XLEN-1:0] held;
        n = 0;
        while (!halted && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            errors++;
            $display("%s: core never halted within 2000 cycles", name);
        end else begin
            held = imem_addr;
            for (n = 0; n < 20; n++) begin
                @(negedge clk);
                assert (imem_addr === held) else report_mismatch("imem_addr", held, imem_addr);
                assert (!retire.valid) else begin
                    errors++;
                    $display("%s: retire.valid went high after HALT at %0t", name, $time);
                end
            end
        end
    endtask

    task automatic run_test(input int kind, input string name);
        int errs_before;
        errs_before = errors;
        if (kind == 5) begin
            // first a run that leaves err and halted set
            build_program(4);
            apply_reset();
            finish_run(name);
            assert (err === 1'b1) else begin
                errors++;
                $display("%s: illegal opcode did not raise err before the reset", name);
            end
        end
        build_program(kind);
        apply_reset();
        finish_run(name);
        tests++;
        if (errors == errs_before) begin
            $display("test %-8s ok", name);
        end else begin
            failed++;
            $display("test %-8s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        imem_data = '0;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        model_reset();
        void'($urandom(32'h71f3));
        run_test(0, "arith");
        run_test(1, "memory");
        run_test(2, "branch");
        run_test(3, "halt");
        run_test(4, "illegal");
        run_test(5, "reset");
        $display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- proc.f
+incdir+design
design/proc_pkg.sv
design/decode.sv
design/exec_alu.sv
design/branch_unit.sv
design/commit.sv
design/proc.sv
dv/proc_tb.sv
